//--- cpu_top.f
+incdir+test
design/pipe_pkg.sv
design/pipe_if.sv
design/fetch_stage.sv
design/pipe_core.sv
design/trace_unit.sv
design/cpu_top.sv
test/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cpu_top testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module cpu_tb -f cpu_top.f -o cpu_tb

sim_out=$(./obj_dir/cpu_tb)
echo "$sim_out"

# the run passes only if the pass message was printed
echo "$sim_out" | grep -qF "*** PASSED ***"

//--- test/tb_model.svh
// test programs and reference model

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int PROG_LEN = 10;   // loaded during reset, one word per cycle
localparam int N_RETIRE = 24;   // retires checked per run

pipe_pkg::instr_t   prog_words [pipe_pkg::PROG_WORDS];
pipe_pkg::pc_t      exp_pc     [N_RETIRE + 1];
logic               exp_wen    [N_RETIRE + 1];
pipe_pkg::reg_idx_t exp_rd     [N_RETIRE + 1];
pipe_pkg::data_t    exp_data   [N_RETIRE + 1];
pipe_pkg::seq_t     exp_seq    [N_RETIRE + 1];
int                 exp_n = 0;

// op in 15..12, rd in 11..10, rs in 9..8, imm in 7..0
function automatic pipe_pkg::instr_t encode(input pipe_pkg::opcode_t  op,
                                            input pipe_pkg::reg_idx_t rd,
                                            input pipe_pkg::reg_idx_t rs,
                                            input pipe_pkg::data_t    imm);
    return {op, rd, rs, imm};
endfunction

task automatic select_program(input int prog);
    if (prog == 0) begin
        // arithmetic chains, each word leans on the one before
        prog_words[0] = encode(pipe_pkg::OP_LI,   2'd0, 2'd0, 8'h05);
        prog_words[1] = encode(pipe_pkg::OP_ADDI, 2'd0, 2'd0, 8'h03);
        prog_words[2] = encode(pipe_pkg::OP_LI,   2'd1, 2'd0, 8'hf0);
        prog_words[3] = encode(pipe_pkg::OP_ADD,  2'd1, 2'd0, 8'h00);
        prog_words[4] = encode(pipe_pkg::OP_SUB,  2'd0, 2'd1, 8'h00);
        prog_words[5] = encode(pipe_pkg::OP_ADDI, 2'd1, 2'd0, 8'h10);
        prog_words[6] = encode(pipe_pkg::OP_ADD,  2'd2, 2'd1, 8'h00);
        prog_words[7] = encode(pipe_pkg::OP_SUB,  2'd3, 2'd2, 8'h00);
        prog_words[8] = encode(pipe_pkg::OP_ADD,  2'd2, 2'd2, 8'h00);
        prog_words[9] = encode(pipe_pkg::OP_JMP,  2'd0, 2'd0, 8'h01);
    end else begin
        // jumps over live words, a jump onto a jump, an unused opcode
        prog_words[0] = encode(pipe_pkg::OP_LI,   2'd0, 2'd0, 8'h01);
        prog_words[1] = encode(pipe_pkg::OP_JMP,  2'd0, 2'd0, 8'h04);
        prog_words[2] = encode(pipe_pkg::OP_LI,   2'd0, 2'd0, 8'h55);
        prog_words[3] = encode(pipe_pkg::OP_LI,   2'd1, 2'd0, 8'h66);
        prog_words[4] = encode(pipe_pkg::OP_ADDI, 2'd0, 2'd0, 8'h01);
        prog_words[5] = encode(pipe_pkg::OP_JMP,  2'd0, 2'd0, 8'h07);
        prog_words[6] = encode(pipe_pkg::OP_JMP,  2'd0, 2'd0, 8'h00);
        prog_words[7] = encode(pipe_pkg::OP_ADD,  2'd1, 2'd0, 8'h00);
        prog_words[8] = 16'hf3ab;
        prog_words[9] = encode(pipe_pkg::OP_JMP,  2'd0, 2'd0, 8'h01);
    end
endtask

// runs the program in order and lists every retire it should produce
task automatic build_expected();
    pipe_pkg::data_t    regs [pipe_pkg::NUM_REGS];
    pipe_pkg::instr_t   word;
    pipe_pkg::pc_t      pc;
    pipe_pkg::seq_t     seq;
    logic [3:0]         op;
    pipe_pkg::reg_idx_t rd;
    pipe_pkg::reg_idx_t rs;
    pipe_pkg::data_t    imm;
    pc  = pipe_pkg::RESET_PC;
    seq = '0;
    for (int r = 0; r < pipe_pkg::NUM_REGS; r++) begin
        regs[r] = '0;
    end
    for (int n = 0; n < N_RETIRE; n++) begin
        word = prog_words[pc];
        op   = word[15:12];
        rd   = word[11:10];
        rs   = word[9:8];
        imm  = word[7:0];
        exp_pc[n]   = pc;
        exp_seq[n]  = seq;
        exp_rd[n]   = rd;
        exp_wen[n]  = 1'b0;
        exp_data[n] = '0;
        case (op)
            pipe_pkg::OP_LI: begin
                exp_wen[n]  = 1'b1;
                exp_data[n] = imm;
            end
            pipe_pkg::OP_ADD: begin
                exp_wen[n]  = 1'b1;
                exp_data[n] = regs[rd] + regs[rs];
            end
            pipe_pkg::OP_SUB: begin
                exp_wen[n]  = 1'b1;
                exp_data[n] = regs[rd] - regs[rs];
            end
            pipe_pkg::OP_ADDI: begin
                exp_wen[n]  = 1'b1;
                exp_data[n] = regs[rd] + imm;
            end
            default: ;
        endcase
        if (exp_wen[n]) begin
            regs[rd] = exp_data[n];
        end
        // a jump leaves two fetched words behind, each took a number
        if (op == pipe_pkg::OP_JMP) begin
            pc  = imm;
            seq = seq + 16'd3;
        end else begin
            pc  = pc + 8'd1;
            seq = seq + 16'd1;
        end
    end
    exp_n = N_RETIRE;
endtask

`endif

//--- test/cpu_tb.sv
// pipelined cpu testbench

module cpu_tb;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_RUNS     = 4;
    localparam int MAX_CYC      = 512;   // cycles tracked per run

    logic               clk;
    logic               rst;
    logic               hold;
    logic               prog_we;
    pipe_pkg::pc_t      prog_addr;
    pipe_pkg::instr_t   prog_data;
    logic               retire_valid;
    pipe_pkg::seq_t     retire_seq;
    pipe_pkg::pc_t      retire_pc;
    logic               retire_wen;
    pipe_pkg::reg_idx_t retire_rd;
    pipe_pkg::data_t    retire_data;
    pipe_pkg::cycle_t   retire_fetch_cycle;
    pipe_pkg::cycle_t   retire_cycle;

    integer             seed;
    int                 errors = 0;
    int                 head = 0;                // next expected retire
    int                 rst_cycles = 0;
    pipe_pkg::cycle_t   tb_cycle = '0;           // cycles since reset
    int                 held_before [MAX_CYC];   // held cycles before index
    int                 held_gap;
    logic               checking;

    `include "tb_model.svh"

    localparam int WATCHDOG_CYCLES = NUM_RUNS * (20 * N_RETIRE + RESET_CYCLES);

    pipe_pkg::pc_t      head_pc;
    logic               head_wen;
    pipe_pkg::reg_idx_t head_rd;
    pipe_pkg::data_t    head_data;
    pipe_pkg::seq_t     head_seq;

    cpu_top u_dut (
        .clk                (clk),
        .rst                (rst),
        .hold               (hold),
        .prog_we            (prog_we),
        .prog_addr          (prog_addr),
        .prog_data          (prog_data),
        .retire_valid       (retire_valid),
        .retire_seq         (retire_seq),
        .retire_pc          (retire_pc),
        .retire_wen         (retire_wen),
        .retire_rd          (retire_rd),
        .retire_data        (retire_data),
        .retire_fetch_cycle (retire_fetch_cycle),
        .retire_cycle       (retire_cycle)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // bookkeeping
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            tb_cycle       <= '0;
            held_before[0] <= 0;
            head           <= 0;
            rst_cycles     <= rst_cycles + 1;
        end else begin
            tb_cycle   <= tb_cycle + 1;
            rst_cycles <= 0;
            if (tb_cycle < MAX_CYC - 1) begin
                held_before[tb_cycle + 1] <= held_before[tb_cycle] + (hold ? 1 : 0);
            end
            if (retire_valid && checking) begin
                head <= head + 1;
            end
        end
    end

    assign checking  = !rst && (head < exp_n);
    assign head_pc   = exp_pc[head];
    assign head_wen  = exp_wen[head];
    assign head_rd   = exp_rd[head];
    assign head_data = exp_data[head];
    assign head_seq  = exp_seq[head];

    // held cycles strictly between fetch and retire
    always_comb begin
        held_gap = 0;
        if (retire_fetch_cycle < tb_cycle && tb_cycle < MAX_CYC) begin
            held_gap = held_before[tb_cycle] - held_before[retire_fetch_cycle + 1];
        end
    end

    task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, sig, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    pc_in_order: assert property (@(posedge clk)
        (retire_valid && checking) |-> retire_pc == head_pc)
        else report_mismatch("retire_pc", 32'($sampled(head_pc)), 32'($sampled(retire_pc)));

    seq_in_order: assert property (@(posedge clk)
        (retire_valid && checking) |-> retire_seq == head_seq)
        else report_mismatch("retire_seq", 32'($sampled(head_seq)), 32'($sampled(retire_seq)));

    wen_matches: assert property (@(posedge clk)
        (retire_valid && checking) |-> retire_wen == head_wen)
        else report_mismatch("retire_wen", 32'($sampled(head_wen)), 32'($sampled(retire_wen)));

    // rd and data only mean something on a register write
    rd_matches: assert property (@(posedge clk)
        (retire_valid && checking && head_wen) |-> retire_rd == head_rd)
        else report_mismatch("retire_rd", 32'($sampled(head_rd)), 32'($sampled(retire_rd)));

    data_matches: assert property (@(posedge clk)
        (retire_valid && checking && head_wen) |-> retire_data == head_data)
        else report_mismatch("retire_data", 32'($sampled(head_data)),
                             32'($sampled(retire_data)));

    cycle_stamp: assert property (@(posedge clk)
        (retire_valid && checking) |-> retire_cycle == tb_cycle)
        else report_mismatch("retire_cycle", $sampled(tb_cycle), $sampled(retire_cycle));

    latency: assert property (@(posedge clk)
        (retire_valid && checking) |->
            (retire_cycle - retire_fetch_cycle) == pipe_pkg::cycle_t'(4 + held_gap))
        else report_mismatch("retire_cycle - retire_fetch_cycle",
                             32'(4 + $sampled(held_gap)),
                             $sampled(retire_cycle) - $sampled(retire_fetch_cycle));

    quiet_in_reset: assert property (@(posedge clk)
        (rst && rst_cycles > 0) |-> !retire_valid)
        else report_failure("retire_valid high while reset is asserted");

    quiet_while_filling: assert property (@(posedge clk)
        (!rst && tb_cycle < 4) |-> !retire_valid)
        else report_failure("retire_valid high before the pipeline could fill");

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    task automatic run_program(input int prog, input logic random_hold);
        rst  = 1'b1;
        hold = 1'b0;
        select_program(prog);
        build_expected();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            if (i < PROG_LEN) begin
                prog_we   = 1'b1;
                prog_addr = pipe_pkg::pc_t'(i);
                prog_data = prog_words[pipe_pkg::pc_t'(i)];
            end else begin
                prog_we = 1'b0;
            end
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        rst     = 1'b0;
        while (head < exp_n) begin
            if (random_hold) begin
                hold = ($random(seed) & 3) == 0;   // about one cycle in four
            end else begin
                hold = 1'b0;
            end
            @(posedge clk);
            #1;
        end
        hold = 1'b0;
    endtask

    initial begin
        seed      = 32'hc260_2503;
        rst       = 1'b1;
        hold      = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        run_program(0, 1'b0);   // arithmetic chains
        run_program(1, 1'b0);   // jump flushes
        run_program(0, 1'b1);
        run_program(1, 1'b1);
        @(posedge clk);
        #1;
        $display("retire checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: retires still missing after %0d cycles, %0d errors so far",
                 WATCHDOG_CYCLES, errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- design/cpu_top.sv
// pipelined cpu top level

module cpu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               hold,
    input  logic               prog_we,
    input  pipe_pkg::pc_t      prog_addr,
    input  pipe_pkg::instr_t   prog_data,
    output logic               retire_valid,
    output pipe_pkg::seq_t     retire_seq,
    output pipe_pkg::pc_t      retire_pc,
    output logic               retire_wen,
    output pipe_pkg::reg_idx_t retire_rd,
    output pipe_pkg::data_t    retire_data,
    output pipe_pkg::cycle_t   retire_fetch_cycle,
    output pipe_pkg::cycle_t   retire_cycle
);

    fetch_if u_fetch_if ();
    trace_if u_trace_if ();

    // input side
    fetch_stage u_fetch (
        .clk       (clk),
        .rst       (rst),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .fi        (u_fetch_if)
    );

    pipe_core u_core (
        .clk  (clk),
        .rst  (rst),
        .hold (hold),
        .fi   (u_fetch_if),
        .tr   (u_trace_if)
    );

    // output side
    trace_unit u_trace (
        .clk                (clk),
        .rst                (rst),
        .tr                 (u_trace_if),
        .retire_valid       (retire_valid),
        .retire_seq         (retire_seq),
        .retire_pc          (retire_pc),
        .retire_wen         (retire_wen),
        .retire_rd          (retire_rd),
        .retire_data        (retire_data),
        .retire_fetch_cycle (retire_fetch_cycle),
        .retire_cycle       (retire_cycle)
    );

endmodule

//--- design/trace_unit.sv
// pipeline trace unit

module trace_unit (
    input  logic               clk,
    input  logic               rst,
    trace_if.trace             tr,
    output logic               retire_valid,
    output pipe_pkg::seq_t     retire_seq,
    output pipe_pkg::pc_t      retire_pc,
    output logic               retire_wen,
    output pipe_pkg::reg_idx_t retire_rd,
    output pipe_pkg::data_t    retire_data,
    output pipe_pkg::cycle_t   retire_fetch_cycle,
    output pipe_pkg::cycle_t   retire_cycle
);

    localparam int WB_TAG = pipe_pkg::TAG_STAGES - 1;

    pipe_pkg::cycle_t cycle_cnt;
    pipe_pkg::seq_t   seq_cnt;                        // tag for the word in fetch
    pipe_pkg::seq_t   seq_tag [pipe_pkg::TAG_STAGES];
    pipe_pkg::cycle_t cyc_tag [pipe_pkg::TAG_STAGES];  // fetch cycle per stage
    pipe_pkg::seq_t   last_seq;
    logic             have_last;

    //////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + pipe_pkg::cycle_t'(1);   // runs through hold
        end
    end

    // flushed fetches still take a number
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_cnt <= '0;
        end else if (tr.advance) begin
            seq_cnt <= seq_cnt + pipe_pkg::seq_t'(1);
        end
    end

    //////////////////////////////////////////////////
    // tag pipeline, aligned with the core stages
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (tr.advance) begin
            if (tr.flush) begin
                seq_tag[0] <= '0;   // the two youngest slots become bubbles
                cyc_tag[0] <= '0;
                seq_tag[1] <= '0;
                cyc_tag[1] <= '0;
            end else begin
                seq_tag[0] <= seq_cnt;
                cyc_tag[0] <= cycle_cnt;
                seq_tag[1] <= seq_tag[0];
                cyc_tag[1] <= cyc_tag[0];
            end
            for (int i = 2; i < pipe_pkg::TAG_STAGES; i++) begin
                seq_tag[i] <= seq_tag[i-1];
                cyc_tag[i] <= cyc_tag[i-1];
            end
        end
    end

    //////////////////////////////////////////////////
    // retire record
    //////////////////////////////////////////////////
    // one record per instruction, taken in the cycle it leaves write-back
    assign retire_valid       = tr.wb_valid && tr.advance;
    assign retire_seq         = seq_tag[WB_TAG];
    assign retire_pc          = tr.wb_pc;
    assign retire_wen         = tr.wb_wen;
    assign retire_rd          = tr.wb_rd;
    assign retire_data        = tr.wb_data;
    assign retire_fetch_cycle = cyc_tag[WB_TAG];
    assign retire_cycle       = cycle_cnt;

    // previous retire, kept for the ordering check
    always_ff @(posedge clk) begin
        if (rst) begin
            have_last <= 1'b0;
            last_seq  <= '0;
        end else if (retire_valid) begin
            have_last <= 1'b1;
            last_seq  <= retire_seq;
        end
    end

    retire_seq_rising: assert property (
        @(posedge clk) disable iff (rst)
        (retire_valid && have_last) |-> (retire_seq > last_seq)
    ) else $error("retire_seq %0d not above previous %0d", retire_seq, last_seq);

endmodule

//--- design/pipe_core.sv
// pipeline core, decode through write-back

module pipe_core (
    input  logic   clk,
    input  logic   rst,
    input  logic   hold,
    fetch_if.core  fi,
    trace_if.core  tr
);

    logic advance;

    // decode
    pipe_pkg::opcode_t  id_op;
    pipe_pkg::reg_idx_t id_rd;
    pipe_pkg::reg_idx_t id_rs;
    pipe_pkg::data_t    id_imm;
    pipe_pkg::data_t    id_a;
    pipe_pkg::data_t    id_b;

    // register file
    pipe_pkg::data_t    rf [pipe_pkg::NUM_REGS];
    logic               rf_we;

    // id/ex register
    logic               de_valid;
    pipe_pkg::opcode_t  de_op;
    pipe_pkg::reg_idx_t de_rd;
    pipe_pkg::reg_idx_t de_rs;
    pipe_pkg::data_t    de_imm;
    pipe_pkg::data_t    de_a;
    pipe_pkg::data_t    de_b;
    pipe_pkg::pc_t      de_pc;

    // execute
    pipe_pkg::data_t    ex_a;
    pipe_pkg::data_t    ex_b;
    pipe_pkg::data_t    ex_result;
    logic               ex_wen;
    logic               ex_jmp;

    // ex/mem register
    logic               em_valid;
    logic               em_wen;
    pipe_pkg::reg_idx_t em_rd;
    pipe_pkg::data_t    em_data;
    pipe_pkg::pc_t      em_pc;

    // mem/wb register
    logic               mw_valid;
    logic               mw_wen;
    pipe_pkg::reg_idx_t mw_rd;
    pipe_pkg::data_t    mw_data;
    pipe_pkg::pc_t      mw_pc;

    assign advance = !hold;

    //////////////////////////////////////////////////
    // decode and register read
    //////////////////////////////////////////////////
    assign id_op  = pipe_pkg::opcode_t'(fi.instr[pipe_pkg::OP_MSB:pipe_pkg::OP_LSB]);
    assign id_rd  = fi.instr[pipe_pkg::RD_MSB:pipe_pkg::RD_LSB];
    assign id_rs  = fi.instr[pipe_pkg::RS_MSB:pipe_pkg::RS_LSB];
    assign id_imm = fi.instr[pipe_pkg::IMM_MSB:pipe_pkg::IMM_LSB];

    assign rf_we = mw_valid && mw_wen;

    // write-through from the write-back stage
    function automatic pipe_pkg::data_t rf_read(input pipe_pkg::reg_idx_t idx);
        if (rf_we && mw_rd == idx) begin
            return mw_data;
        end
        return rf[idx];
    endfunction

    assign id_a = rf_read(id_rd);
    assign id_b = rf_read(id_rs);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < pipe_pkg::NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we) begin
            rf[mw_rd] <= mw_data;   // end of the write-back cycle
        end
    end

    //////////////////////////////////////////////////
    // execute with forwarding
    //////////////////////////////////////////////////
    // mem stage is younger, so it wins over wb
    function automatic pipe_pkg::data_t fwd(input pipe_pkg::reg_idx_t idx,
                                            input pipe_pkg::data_t    regval);
        if (em_valid && em_wen && em_rd == idx) begin
            return em_data;
        end
        if (mw_valid && mw_wen && mw_rd == idx) begin
            return mw_data;
        end
        return regval;
    endfunction

    assign ex_a = fwd(de_rd, de_a);
    assign ex_b = fwd(de_rs, de_b);

    always_comb begin
        ex_result = '0;
        ex_wen    = 1'b0;
        case (de_op)
            pipe_pkg::OP_LI: begin
                ex_result = de_imm;
                ex_wen    = de_valid;
            end
            pipe_pkg::OP_ADD: begin
                ex_result = ex_a + ex_b;   // wraps mod 256
                ex_wen    = de_valid;
            end
            pipe_pkg::OP_SUB: begin
                ex_result = ex_a - ex_b;
                ex_wen    = de_valid;
            end
            pipe_pkg::OP_ADDI: begin
                ex_result = ex_a + de_imm;
                ex_wen    = de_valid;
            end
            default: ;                      // nop, jmp and unused codes
        endcase
    end

    assign ex_jmp = de_valid && (de_op == pipe_pkg::OP_JMP);

    //////////////////////////////////////////////////
    // stage registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            de_valid <= 1'b0;
            em_valid <= 1'b0;
            em_wen   <= 1'b0;
            mw_valid <= 1'b0;
            mw_wen   <= 1'b0;
        end else if (advance) begin
            de_valid <= fi.valid && !ex_jmp;   // jmp drops the id slot
            em_valid <= de_valid;
            em_wen   <= ex_wen;
            mw_valid <= em_valid;
            mw_wen   <= em_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            de_op   <= id_op;
            de_rd   <= id_rd;
            de_rs   <= id_rs;
            de_imm  <= id_imm;
            de_a    <= id_a;
            de_b    <= id_b;
            de_pc   <= fi.pc;
            em_rd   <= de_rd;
            em_data <= ex_result;
            em_pc   <= de_pc;
            // memory stage only passes its contents on
            mw_rd   <= em_rd;
            mw_data <= em_data;
            mw_pc   <= em_pc;
        end
    end

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////
    assign fi.stall    = hold;
    assign fi.redirect = ex_jmp;
    assign fi.target   = pipe_pkg::pc_t'(de_imm);

    assign tr.advance  = advance;
    assign tr.flush    = ex_jmp;
    assign tr.wb_valid = mw_valid;
    assign tr.wb_pc    = mw_pc;
    assign tr.wb_wen   = mw_wen;
    assign tr.wb_rd    = mw_rd;
    assign tr.wb_data  = mw_data;

    // write enables come from execute gated by a valid, flushed slots carry none
    wb_wen_implies_valid: assert property (
        @(posedge clk) disable iff (rst)
        tr.wb_wen |-> tr.wb_valid
    ) else $error("wb_wen high on an empty write-back slot");

endmodule

//--- design/fetch_stage.sv
// instruction fetch stage

module fetch_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             prog_we,
    input  pipe_pkg::pc_t    prog_addr,
    input  pipe_pkg::instr_t prog_data,
    fetch_if.fetch           fi
);

    pipe_pkg::instr_t prog_mem [pipe_pkg::PROG_WORDS];   // program ram
    pipe_pkg::pc_t    pc;
    logic             advance;

    assign advance = !fi.stall;

    //////////////////////////////////////////////////
    // program ram, writable at any time
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (prog_we) begin
            prog_mem[prog_addr] <= prog_data;
        end
    end

    //////////////////////////////////////////////////
    // pc and if/id valid
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= pipe_pkg::RESET_PC;
            fi.valid <= 1'b0;
        end else if (advance) begin
            // a redirect kills the word fetched in this cycle
            fi.valid <= !fi.redirect;
            if (fi.redirect) begin
                pc <= fi.target;
            end else begin
                pc <= pc + pipe_pkg::pc_t'(1);
            end
        end
    end

    // if/id payload
    always_ff @(posedge clk) begin
        if (advance) begin
            fi.instr <= prog_mem[pc];
            fi.pc    <= pc;
        end
    end

    // an advancing redirect empties id/ex, so the pulse cannot repeat next cycle
    redirect_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        (fi.redirect && advance) |=> !fi.redirect
    ) else $error("redirect held across advancing cycles");

endmodule

//--- design/pipe_if.sv
// pipeline interfaces

// if/id register and the control coming back from the core
interface fetch_if;
    pipe_pkg::instr_t instr;
    pipe_pkg::pc_t    pc;
    logic             valid;
    logic             stall;
    logic             redirect;   // jmp in execute
    pipe_pkg::pc_t    target;

    modport fetch (
        output instr, pc, valid,
        input  stall, redirect, target
    );

    modport core (
        input  instr, pc, valid,
        output stall, redirect, target
    );
endinterface

// pipeline control and write-back view for the trace unit
interface trace_if;
    logic               advance;
    logic               flush;
    logic               wb_valid;
    pipe_pkg::pc_t      wb_pc;
    logic               wb_wen;
    pipe_pkg::reg_idx_t wb_rd;
    pipe_pkg::data_t    wb_data;

    modport core (
        output advance, flush, wb_valid, wb_pc, wb_wen, wb_rd, wb_data
    );

    modport trace (
        input  advance, flush, wb_valid, wb_pc, wb_wen, wb_rd, wb_data
    );
endinterface

//--- design/pipe_pkg.sv
// pipeline processor package

package pipe_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int DATA_W     = 8;
    localparam int PC_W       = 8;
    localparam int INSTR_W    = 16;
    localparam int REG_IDX_W  = 2;
    localparam int SEQ_W      = 16;
    localparam int CYCLE_W    = 32;
    localparam int OP_W       = 4;

    localparam int NUM_REGS   = 4;
    localparam int PROG_WORDS = 256;   // one word per pc value
    localparam int TAG_STAGES = 4;     // if/id, id/ex, ex/mem, mem/wb

    //////////////////////////////////////////////////
    // instruction fields
    //////////////////////////////////////////////////
    localparam int OP_MSB  = 15;
    localparam int OP_LSB  = 12;
    localparam int RD_MSB  = 11;
    localparam int RD_LSB  = 10;
    localparam int RS_MSB  = 9;
    localparam int RS_LSB  = 8;
    localparam int IMM_MSB = 7;
    localparam int IMM_LSB = 0;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [PC_W-1:0]      pc_t;
    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [SEQ_W-1:0]     seq_t;     // instruction sequence number
    typedef logic [CYCLE_W-1:0]   cycle_t;   // cycles since reset

    // codes not listed here decode as nop
    typedef enum logic [OP_W-1:0] {
        OP_NOP  = 4'd0,
        OP_LI   = 4'd1,
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_ADDI = 4'd4,
        OP_JMP  = 4'd5
    } opcode_t;

    localparam pc_t RESET_PC = '0;

endpackage
